// File: hw/fpu_pkg.sv
// fpu shared definitions
`default_nettype none

package fpu_pkg;

   // packed ieee single word
   typedef logic [31:0] fp_word_t;
   // biased exponent field
   typedef logic [7:0] exp_t;
   // exponent with headroom for over and underflow
   typedef logic signed [9:0] wide_exp_t;
   // hidden bit, 23 fraction bits, guard, round
   typedef logic [25:0] frac_t;
   // operation code
   typedef logic [6:0] funct_t;
   // rounding mode
   typedef logic [2:0] frm_t;
   // exception flags
   typedef logic [4:0] flags_t;

   // operation codes
   localparam funct_t FUNCT_ADD = 7'b0100000;
   localparam funct_t FUNCT_SUB = 7'b0100100;
   localparam funct_t FUNCT_MUL = 7'b0000010;

   // rounding modes, others fall back to nearest-even
   localparam frm_t FRM_RNE = 3'b000;
   localparam frm_t FRM_RTZ = 3'b001;
   localparam frm_t FRM_RDN = 3'b010;
   localparam frm_t FRM_RUP = 3'b011;
   localparam frm_t FRM_RMM = 3'b100;

   // flag bit positions
   localparam int FLAG_NV = 4;
   localparam int FLAG_DZ = 3;
   localparam int FLAG_OF = 2;
   localparam int FLAG_UF = 1;
   localparam int FLAG_NX = 0;

   // canonical quiet nan
   localparam fp_word_t QNAN_WORD = 32'h7FC00000;
   localparam exp_t EXP_BIAS = 8'd127;

endpackage

`default_nettype wire

// File: hw/fpu_decode.sv
// fpu decode stage
`timescale 1ns/1ps
`default_nettype none

module fpu_decode (
   input  wire                       clk,
   input  wire                       nrst,
   input  wire fpu_pkg::fp_word_t    operand_a,
   input  wire fpu_pkg::fp_word_t    operand_b,
   input  wire fpu_pkg::funct_t      funct,
   input  wire fpu_pkg::frm_t        frm,
   output fpu_pkg::funct_t           d_funct,
   output fpu_pkg::frm_t             d_frm,
   output logic                      d_sign_a,
   output logic                      d_sign_b,
   output fpu_pkg::exp_t             d_exp_a,
   output fpu_pkg::exp_t             d_exp_b,
   output fpu_pkg::frac_t            d_frac_a,
   output fpu_pkg::frac_t            d_frac_b,
   output logic                      d_carry,
   output logic                      d_special,
   output fpu_pkg::fp_word_t         d_special_word,
   output fpu_pkg::flags_t           d_special_flags
);

   logic              sign_a;
   logic              sign_b;
   logic              sign_b_eff;
   fpu_pkg::exp_t     exp_a;
   fpu_pkg::exp_t     exp_b;
   logic              zero_a;
   logic              zero_b;
   logic              inf_a;
   logic              inf_b;
   logic              nan_a;
   logic              nan_b;
   logic [23:0]       sig_a;
   logic [23:0]       sig_b;
   logic              is_add;
   logic              is_mul;
   logic              a_larger;
   fpu_pkg::exp_t     exp_big;
   fpu_pkg::exp_t     exp_small;
   fpu_pkg::exp_t     shift_amt;
   fpu_pkg::frac_t    frac_big;
   fpu_pkg::frac_t    frac_small;
   logic [47:0]       product;
   logic              special;
   fpu_pkg::fp_word_t special_word;
   fpu_pkg::flags_t   special_flags;

   // field unpack
   assign sign_a = operand_a[31];
   assign sign_b = operand_b[31];
   assign exp_a  = operand_a[30:23];
   assign exp_b  = operand_b[30:23];

   // exp 0 reads as zero so denormals flush
   assign zero_a = (exp_a == 8'h00);
   assign zero_b = (exp_b == 8'h00);
   assign inf_a  = (exp_a == 8'hFF) && (operand_a[22:0] == 23'h0);
   assign inf_b  = (exp_b == 8'hFF) && (operand_b[22:0] == 23'h0);
   assign nan_a  = (exp_a == 8'hFF) && (operand_a[22:0] != 23'h0);
   assign nan_b  = (exp_b == 8'hFF) && (operand_b[22:0] != 23'h0);

   // significands with hidden bit
   assign sig_a = zero_a ? 24'h0 : {1'b1, operand_a[22:0]};
   assign sig_b = zero_b ? 24'h0 : {1'b1, operand_b[22:0]};

   assign is_add = (funct == fpu_pkg::FUNCT_ADD) || (funct == fpu_pkg::FUNCT_SUB);
   assign is_mul = (funct == fpu_pkg::FUNCT_MUL);

   // sub is add with b negated
   assign sign_b_eff = sign_b ^ (funct == fpu_pkg::FUNCT_SUB);

   // magnitude compare on exp and fraction together
   assign a_larger  = (operand_a[30:0] >= operand_b[30:0]);
   assign exp_big   = a_larger ? exp_a : exp_b;
   assign exp_small = a_larger ? exp_b : exp_a;
   assign shift_amt = exp_big - exp_small;

   // align smaller and drop bits past round
   assign frac_big   = a_larger ? {sig_a, 2'b00} : {sig_b, 2'b00};
   assign frac_small = (a_larger ? {sig_b, 2'b00} : {sig_a, 2'b00}) >> shift_amt;

   // full significand product with carry at bit 47
   assign product = {24'h0, sig_a} * {24'h0, sig_b};

   // special operand results decided here and carried down
   always_comb begin
      special       = 1'b0;
      special_word  = 32'h0;
      special_flags = 5'h0;
      if (is_add) begin
         special = nan_a || nan_b || inf_a || inf_b || (zero_a && zero_b);
         if (nan_a || nan_b) begin
            special_word = fpu_pkg::QNAN_WORD;
         end else if (inf_a && inf_b && (sign_a != sign_b_eff)) begin
            // inf - inf
            special_word = fpu_pkg::QNAN_WORD;
            special_flags[fpu_pkg::FLAG_NV] = 1'b1;
         end else if (inf_a) begin
            special_word = {sign_a, 8'hFF, 23'h0};
         end else if (inf_b) begin
            special_word = {sign_b_eff, 8'hFF, 23'h0};
         end else begin
            // -0 only when both are -0
            special_word = {sign_a & sign_b_eff, 31'h0};
         end
      end else if (is_mul) begin
         special = nan_a || nan_b || inf_a || inf_b || zero_a || zero_b;
         if (nan_a || nan_b) begin
            special_word = fpu_pkg::QNAN_WORD;
         end else if ((zero_a && inf_b) || (inf_a && zero_b)) begin
            special_word = fpu_pkg::QNAN_WORD;
            special_flags[fpu_pkg::FLAG_NV] = 1'b1;
         end else if (inf_a || inf_b) begin
            special_word = {sign_a ^ sign_b, 8'hFF, 23'h0};
         end else begin
            special_word = {sign_a ^ sign_b, 31'h0};
         end
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         d_funct         <= '0;
         d_frm           <= '0;
         d_sign_a        <= 1'b0;
         d_sign_b        <= 1'b0;
         d_exp_a         <= '0;
         d_exp_b         <= '0;
         d_frac_a        <= '0;
         d_frac_b        <= '0;
         d_carry         <= 1'b0;
         d_special       <= 1'b0;
         d_special_word  <= '0;
         d_special_flags <= '0;
      end else begin
         d_funct         <= funct;
         d_frm           <= frm;
         d_special       <= special;
         d_special_word  <= special_word;
         d_special_flags <= special_flags;
         if (is_mul) begin
            d_sign_a <= sign_a;
            d_sign_b <= sign_b;
            d_exp_a  <= exp_a;
            d_exp_b  <= exp_b;
            // top 26 bits below the carry
            d_frac_a <= product[46:21];
            d_frac_b <= '0;
            d_carry  <= product[47];
         end else begin
            // a side is the shifted one
            d_sign_a <= a_larger ? sign_b_eff : sign_a;
            d_sign_b <= a_larger ? sign_a : sign_b_eff;
            d_exp_a  <= exp_big;
            d_exp_b  <= exp_small;
            d_frac_a <= frac_small;
            d_frac_b <= frac_big;
            d_carry  <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/fpu_execute.sv
// fpu execute stage
`timescale 1ns/1ps
`default_nettype none

module fpu_execute (
   input  wire                       clk,
   input  wire                       nrst,
   input  wire fpu_pkg::funct_t      d_funct,
   input  wire fpu_pkg::frm_t        d_frm,
   input  wire                       d_sign_a,
   input  wire                       d_sign_b,
   input  wire fpu_pkg::exp_t        d_exp_a,
   input  wire fpu_pkg::exp_t        d_exp_b,
   input  wire fpu_pkg::frac_t       d_frac_a,
   input  wire fpu_pkg::frac_t       d_frac_b,
   input  wire                       d_carry,
   input  wire                       d_special,
   input  wire fpu_pkg::fp_word_t    d_special_word,
   input  wire fpu_pkg::flags_t      d_special_flags,
   output fpu_pkg::funct_t           e_funct,
   output fpu_pkg::frm_t             e_frm,
   output logic                      e_sign,
   output fpu_pkg::wide_exp_t        e_exp,
   output fpu_pkg::frac_t            e_frac,
   output logic                      e_carry,
   output logic                      e_special,
   output fpu_pkg::fp_word_t         e_special_word,
   output fpu_pkg::flags_t           e_special_flags
);

   logic               is_mul;
   logic [26:0]        mag_sum;
   fpu_pkg::frac_t     mag_diff;
   fpu_pkg::wide_exp_t mul_exp;
   logic               sign_n;
   fpu_pkg::wide_exp_t exp_n;
   fpu_pkg::frac_t     frac_n;
   logic               carry_n;

   assign is_mul = (d_funct == fpu_pkg::FUNCT_MUL);

   // b holds the larger magnitude, so no borrow
   assign mag_sum  = {1'b0, d_frac_a} + {1'b0, d_frac_b};
   assign mag_diff = d_frac_b - d_frac_a;

   // biased sum, one bias removed
   assign mul_exp = fpu_pkg::wide_exp_t'({2'b00, d_exp_a})
                  + fpu_pkg::wide_exp_t'({2'b00, d_exp_b})
                  - fpu_pkg::wide_exp_t'({2'b00, fpu_pkg::EXP_BIAS});

   always_comb begin
      if (is_mul) begin
         sign_n  = d_sign_a ^ d_sign_b;
         exp_n   = mul_exp;
         frac_n  = d_frac_a;
         carry_n = d_carry;
      end else if (d_sign_a == d_sign_b) begin
         // same sign, magnitudes add
         sign_n  = d_sign_b;
         exp_n   = fpu_pkg::wide_exp_t'({2'b00, d_exp_a});
         frac_n  = mag_sum[25:0];
         carry_n = mag_sum[26];
      end else begin
         // exact cancellation comes out +0
         sign_n  = (mag_diff == '0) ? 1'b0 : d_sign_b;
         exp_n   = fpu_pkg::wide_exp_t'({2'b00, d_exp_a});
         frac_n  = mag_diff;
         carry_n = 1'b0;
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         e_funct         <= '0;
         e_frm           <= '0;
         e_sign          <= 1'b0;
         e_exp           <= '0;
         e_frac          <= '0;
         e_carry         <= 1'b0;
         e_special       <= 1'b0;
         e_special_word  <= '0;
         e_special_flags <= '0;
      end else begin
         e_funct         <= d_funct;
         e_frm           <= d_frm;
         e_sign          <= sign_n;
         e_exp           <= exp_n;
         e_frac          <= frac_n;
         e_carry         <= carry_n;
         e_special       <= d_special;
         e_special_word  <= d_special_word;
         e_special_flags <= d_special_flags;
      end
   end

endmodule

`default_nettype wire

// File: hw/fpu_result.sv
// fpu normalize and round stage
`timescale 1ns/1ps
`default_nettype none

module fpu_result (
   input  wire                       clk,
   input  wire                       nrst,
   input  wire fpu_pkg::funct_t      e_funct,
   input  wire fpu_pkg::frm_t        e_frm,
   input  wire                       e_sign,
   input  wire fpu_pkg::wide_exp_t   e_exp,
   input  wire fpu_pkg::frac_t       e_frac,
   input  wire                       e_carry,
   input  wire                       e_special,
   input  wire fpu_pkg::fp_word_t    e_special_word,
   input  wire fpu_pkg::flags_t      e_special_flags,
   output fpu_pkg::fp_word_t         result,
   output fpu_pkg::flags_t           flags
);

   logic               op_known;
   logic [4:0]         lead_zeros;
   fpu_pkg::frac_t     norm_frac;
   fpu_pkg::wide_exp_t norm_exp;
   logic               guard;
   logic               rnd;
   logic               lsb;
   logic               inexact;
   logic               rne_up;
   logic               round_up;
   logic [24:0]        rounded;
   logic [22:0]        final_man;
   fpu_pkg::wide_exp_t final_exp;
   fpu_pkg::fp_word_t  result_n;
   fpu_pkg::flags_t    flags_n;

   assign op_known = (e_funct == fpu_pkg::FUNCT_ADD) || (e_funct == fpu_pkg::FUNCT_SUB)
                   || (e_funct == fpu_pkg::FUNCT_MUL);

   // leading zeros, highest set bit wins
   always_comb begin
      lead_zeros = 5'd0;
      for (int i = 0; i < 26; i++) begin
         if (e_frac[i]) begin
            lead_zeros = 5'(25 - i);
         end
      end
   end

   // normalize to hidden bit at 25
   always_comb begin
      if (e_carry) begin
         // carry becomes hidden bit, lowest bit lost
         norm_frac = {1'b1, e_frac[25:1]};
         norm_exp  = e_exp + 10'sd1;
      end else begin
         norm_frac = e_frac << lead_zeros;
         norm_exp  = e_exp - fpu_pkg::wide_exp_t'({5'd0, lead_zeros});
      end
   end

   // two extra bits only
   assign guard   = norm_frac[1];
   assign rnd     = norm_frac[0];
   assign lsb     = norm_frac[2];
   assign inexact = guard | rnd;
   assign rne_up  = guard & (rnd | lsb);

   always_comb begin
      case (e_frm)
         fpu_pkg::FRM_RNE: round_up = rne_up;
         fpu_pkg::FRM_RTZ: round_up = 1'b0;
         fpu_pkg::FRM_RDN: round_up = e_sign & inexact;
         fpu_pkg::FRM_RUP: round_up = ~e_sign & inexact;
         fpu_pkg::FRM_RMM: round_up = guard;
         // unused codes act as nearest-even
         default:          round_up = rne_up;
      endcase
   end

   assign rounded = {1'b0, norm_frac[25:2]} + {24'd0, round_up};

   // rounding carry renormalizes
   assign final_man = rounded[24] ? rounded[23:1] : rounded[22:0];
   assign final_exp = norm_exp + (rounded[24] ? 10'sd1 : 10'sd0);

   always_comb begin
      result_n = {e_sign, final_exp[7:0], final_man};
      flags_n  = '0;
      flags_n[fpu_pkg::FLAG_NX] = inexact;
      // no divide in this unit
      flags_n[fpu_pkg::FLAG_DZ] = 1'b0;
      if (!op_known) begin
         result_n = '0;
         flags_n  = '0;
      end else if (e_special) begin
         result_n = e_special_word;
         flags_n  = e_special_flags;
      end else if (!e_carry && (e_frac == '0)) begin
         // zero sum is +0
         result_n = '0;
         flags_n  = '0;
      end else if (final_exp >= 10'sd255) begin
         result_n = {e_sign, 8'hFF, 23'h0};
         flags_n[fpu_pkg::FLAG_OF] = 1'b1;
         flags_n[fpu_pkg::FLAG_NX] = 1'b1;
      end else if (final_exp <= 10'sd0) begin
         // flush to signed zero
         result_n = {e_sign, 31'h0};
         flags_n[fpu_pkg::FLAG_UF] = 1'b1;
         flags_n[fpu_pkg::FLAG_NX] = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         result <= '0;
         flags  <= '0;
      end else begin
         result <= result_n;
         flags  <= flags_n;
      end
   end

endmodule

`default_nettype wire

// File: hw/fpu_top.sv
// three-stage fpu
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
   input  wire                       clk,
   input  wire                       nrst,
   input  wire fpu_pkg::fp_word_t    operand_a,
   input  wire fpu_pkg::fp_word_t    operand_b,
   input  wire fpu_pkg::funct_t      funct,
   input  wire fpu_pkg::frm_t        frm,
   output fpu_pkg::fp_word_t         result,
   output fpu_pkg::flags_t           flags
);

   // decode to execute
   fpu_pkg::funct_t    d_funct;
   fpu_pkg::frm_t      d_frm;
   logic               d_sign_a;
   logic               d_sign_b;
   fpu_pkg::exp_t      d_exp_a;
   fpu_pkg::exp_t      d_exp_b;
   fpu_pkg::frac_t     d_frac_a;
   fpu_pkg::frac_t     d_frac_b;
   logic               d_carry;
   logic               d_special;
   fpu_pkg::fp_word_t  d_special_word;
   fpu_pkg::flags_t    d_special_flags;

   // execute to result
   fpu_pkg::funct_t    e_funct;
   fpu_pkg::frm_t      e_frm;
   logic               e_sign;
   fpu_pkg::wide_exp_t e_exp;
   fpu_pkg::frac_t     e_frac;
   logic               e_carry;
   logic               e_special;
   fpu_pkg::fp_word_t  e_special_word;
   fpu_pkg::flags_t    e_special_flags;

   fpu_decode u_decode (
      .clk             (clk),
      .nrst            (nrst),
      .operand_a       (operand_a),
      .operand_b       (operand_b),
      .funct           (funct),
      .frm             (frm),
      .d_funct         (d_funct),
      .d_frm           (d_frm),
      .d_sign_a        (d_sign_a),
      .d_sign_b        (d_sign_b),
      .d_exp_a         (d_exp_a),
      .d_exp_b         (d_exp_b),
      .d_frac_a        (d_frac_a),
      .d_frac_b        (d_frac_b),
      .d_carry         (d_carry),
      .d_special       (d_special),
      .d_special_word  (d_special_word),
      .d_special_flags (d_special_flags)
   );

   fpu_execute u_execute (
      .clk             (clk),
      .nrst            (nrst),
      .d_funct         (d_funct),
      .d_frm           (d_frm),
      .d_sign_a        (d_sign_a),
      .d_sign_b        (d_sign_b),
      .d_exp_a         (d_exp_a),
      .d_exp_b         (d_exp_b),
      .d_frac_a        (d_frac_a),
      .d_frac_b        (d_frac_b),
      .d_carry         (d_carry),
      .d_special       (d_special),
      .d_special_word  (d_special_word),
      .d_special_flags (d_special_flags),
      .e_funct         (e_funct),
      .e_frm           (e_frm),
      .e_sign          (e_sign),
      .e_exp           (e_exp),
      .e_frac          (e_frac),
      .e_carry         (e_carry),
      .e_special       (e_special),
      .e_special_word  (e_special_word),
      .e_special_flags (e_special_flags)
   );

   fpu_result u_result (
      .clk             (clk),
      .nrst            (nrst),
      .e_funct         (e_funct),
      .e_frm           (e_frm),
      .e_sign          (e_sign),
      .e_exp           (e_exp),
      .e_frac          (e_frac),
      .e_carry         (e_carry),
      .e_special       (e_special),
      .e_special_word  (e_special_word),
      .e_special_flags (e_special_flags),
      .result          (result),
      .flags           (flags)
   );

endmodule

`default_nettype wire

// File: testbench/fpu_tb.sv
// fpu pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

   logic              clk;
   logic              nrst;
   fpu_pkg::fp_word_t operand_a;
   fpu_pkg::fp_word_t operand_b;
   fpu_pkg::funct_t   funct;
   fpu_pkg::frm_t     frm;
   fpu_pkg::fp_word_t result;
   fpu_pkg::flags_t   flags;

   // expected results with the oldest first
   string             name_q[$];
   fpu_pkg::fp_word_t word_q[$];
   fpu_pkg::flags_t   flags_q[$];
   int                due_q[$];

   int                edge_count = 0;
   int                word_errors = 0;
   int                flag_errors = 0;
   int                drain_errors = 0;
   logic [31:0]       rng = 32'd78;

   // operand pairs landing on guard and round bits
   fpu_pkg::fp_word_t pair_a[5] = '{32'h3F800000, 32'h3F800000, 32'hBF800000,
                                    32'h3F800000, 32'h3FC00001};
   fpu_pkg::fp_word_t pair_b[5] = '{32'h33C00000, 32'h33800000, 32'hB3C00000,
                                    32'h33C00000, 32'h3FC00001};
   fpu_pkg::funct_t   pair_op[5] = '{fpu_pkg::FUNCT_ADD, fpu_pkg::FUNCT_ADD, fpu_pkg::FUNCT_ADD,
                                     fpu_pkg::FUNCT_SUB, fpu_pkg::FUNCT_MUL};
   // five modes plus one unused code
   fpu_pkg::frm_t     mode_list[6] = '{fpu_pkg::FRM_RNE, fpu_pkg::FRM_RTZ, fpu_pkg::FRM_RDN,
                                       fpu_pkg::FRM_RUP, fpu_pkg::FRM_RMM, 3'b111};

   fpu_top DUT (
      .clk       (clk),
      .nrst      (nrst),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .funct     (funct),
      .frm       (frm),
      .result    (result),
      .flags     (flags)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      edge_count <= edge_count + 1;
   end

   // reference model with flushed denormals and truncated alignment
   // only two extra bits and no sticky
   function automatic void fpu_model(input fpu_pkg::fp_word_t a, input fpu_pkg::fp_word_t b,
                                     input fpu_pkg::funct_t fn, input fpu_pkg::frm_t rm,
                                     output fpu_pkg::fp_word_t w, output fpu_pkg::flags_t f);
      int          ea;
      int          eb;
      int          e;
      logic        sa;
      logic        sb;
      logic        s;
      logic        za, zb, ia, ib, na, nb;
      logic        g, r, up;
      logic [25:0] siga;
      logic [25:0] sigb;
      logic [25:0] big;
      logic [25:0] lesser;
      logic [47:0] prod;
      logic [26:0] sum;
      logic [24:0] mant;
      w  = '0;
      f  = '0;
      sa = a[31];
      sb = b[31] ^ (fn == fpu_pkg::FUNCT_SUB);
      ea = int'(a[30:23]);
      eb = int'(b[30:23]);
      za = (ea == 0);
      zb = (eb == 0);
      ia = (ea == 255) && (a[22:0] == 23'h0);
      ib = (eb == 255) && (b[22:0] == 23'h0);
      na = (ea == 255) && (a[22:0] != 23'h0);
      nb = (eb == 255) && (b[22:0] != 23'h0);
      siga = za ? 26'h0 : {1'b1, a[22:0], 2'b00};
      sigb = zb ? 26'h0 : {1'b1, b[22:0], 2'b00};
      if (fn != fpu_pkg::FUNCT_ADD && fn != fpu_pkg::FUNCT_SUB && fn != fpu_pkg::FUNCT_MUL) begin
         return;
      end
      if (na || nb) begin
         w = fpu_pkg::QNAN_WORD;
         return;
      end
      if (fn == fpu_pkg::FUNCT_MUL) begin
         s = sa ^ sb;
         if ((za && ib) || (ia && zb)) begin
            w = fpu_pkg::QNAN_WORD;
            f[fpu_pkg::FLAG_NV] = 1'b1;
            return;
         end
         if (ia || ib) begin
            w = {s, 8'hFF, 23'h0};
            return;
         end
         if (za || zb) begin
            w = {s, 31'h0};
            return;
         end
         prod = {24'h0, 1'b1, a[22:0]} * {24'h0, 1'b1, b[22:0]};
         // carry bit plus 26 bits below it
         sum  = prod[47:21];
         e    = ea + eb - 127;
      end else begin
         if (ia && ib && (sa != sb)) begin
            w = fpu_pkg::QNAN_WORD;
            f[fpu_pkg::FLAG_NV] = 1'b1;
            return;
         end
         if (ia || ib) begin
            w = {ia ? sa : sb, 8'hFF, 23'h0};
            return;
         end
         if (za && zb) begin
            w = {sa & sb, 31'h0};
            return;
         end
         // larger magnitude sets exponent and sign
         if (a[30:0] >= b[30:0]) begin
            e      = ea;
            s      = sa;
            big    = siga;
            lesser = sigb >> (ea - eb);
         end else begin
            e      = eb;
            s      = sb;
            big    = sigb;
            lesser = siga >> (eb - ea);
         end
         if (sa == sb) begin
            sum = {1'b0, big} + {1'b0, lesser};
         end else begin
            sum = {1'b0, big - lesser};
            if (sum == 27'h0) begin
               return;
            end
         end
      end
      if (sum[26]) begin
         sum = sum >> 1;
         e   = e + 1;
      end
      while (!sum[25]) begin
         sum = sum << 1;
         e   = e - 1;
      end
      g = sum[1];
      r = sum[0];
      case (rm)
         fpu_pkg::FRM_RTZ: up = 1'b0;
         fpu_pkg::FRM_RDN: up = s & (g | r);
         fpu_pkg::FRM_RUP: up = ~s & (g | r);
         fpu_pkg::FRM_RMM: up = g;
         default:          up = g & (r | sum[2]);
      endcase
      mant = {1'b0, sum[25:2]} + {24'h0, up};
      if (mant[24]) begin
         mant = mant >> 1;
         e    = e + 1;
      end
      if (e >= 255) begin
         w = {s, 8'hFF, 23'h0};
         f[fpu_pkg::FLAG_OF] = 1'b1;
         f[fpu_pkg::FLAG_NX] = 1'b1;
      end else if (e <= 0) begin
         w = {s, 31'h0};
         f[fpu_pkg::FLAG_UF] = 1'b1;
         f[fpu_pkg::FLAG_NX] = 1'b1;
      end else begin
         w = {s, e[7:0], mant[22:0]};
         f[fpu_pkg::FLAG_NX] = g | r;
      end
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // normal operand with half the exponents in a narrow band
   function automatic fpu_pkg::fp_word_t random_normal(input logic [31:0] r1,
                                                        input logic [31:0] r2);
      fpu_pkg::exp_t e;
      e = r2[8] ? (8'd1 + (r2[7:0] % 8'd254)) : (8'd120 + {4'h0, r2[3:0]});
      return {r2[9], e, r1[22:0]};
   endfunction

   task automatic check_word(input string name, input fpu_pkg::fp_word_t expected,
                             input fpu_pkg::fp_word_t actual);
      if (actual !== expected) begin
         word_errors++;
         $display("mismatch %s: result expected %08h actual %08h", name, expected, actual);
      end
   endtask

   task automatic check_flags(input string name, input fpu_pkg::flags_t expected,
                              input fpu_pkg::flags_t actual);
      if (actual !== expected) begin
         flag_errors++;
         $display("mismatch %s: flags expected %05b actual %05b", name, expected, actual);
      end
   endtask

   // drive one operation and queue its expected outcome
   task automatic issue(input string name, input fpu_pkg::fp_word_t a,
                        input fpu_pkg::fp_word_t b, input fpu_pkg::funct_t op,
                        input fpu_pkg::frm_t rm);
      fpu_pkg::fp_word_t exp_word;
      fpu_pkg::flags_t   exp_flags;
      @(negedge clk);
      operand_a = a;
      operand_b = b;
      funct     = op;
      frm       = rm;
      fpu_model(a, b, op, rm, exp_word, exp_flags);
      name_q.push_back(name);
      word_q.push_back(exp_word);
      flags_q.push_back(exp_flags);
      // sampled at next edge and registered three edges on
      due_q.push_back(edge_count + 3);
   endtask

   // outputs only move on the rising edge
   always @(negedge clk) begin
      if (due_q.size() > 0 && due_q[0] == edge_count) begin
         check_word(name_q[0], word_q[0], result);
         check_flags(name_q[0], flags_q[0], flags);
         void'(name_q.pop_front());
         void'(word_q.pop_front());
         void'(flags_q.pop_front());
         void'(due_q.pop_front());
      end
   end

   initial begin
      logic [31:0]     r1, r2, r3, r4;
      fpu_pkg::funct_t op;
      int              wait_cycles;
      clk       = 1'b0;
      nrst      = 1'b0;
      operand_a = '0;
      operand_b = '0;
      funct     = '0;
      frm       = '0;
      repeat (3) @(negedge clk);
      nrst = 1'b1;
      check_word("reset", '0, result);
      check_flags("reset", '0, flags);

      issue("add 1.5+2.25", 32'h3FC00000, 32'h40100000, fpu_pkg::FUNCT_ADD, fpu_pkg::FRM_RNE);
      issue("add 2.25+1.5", 32'h40100000, 32'h3FC00000, fpu_pkg::FUNCT_ADD, fpu_pkg::FRM_RNE);
      issue("sub 3-5", 32'h40400000, 32'h40A00000, fpu_pkg::FUNCT_SUB, fpu_pkg::FRM_RNE);
      issue("sub 5-3", 32'h40A00000, 32'h40400000, fpu_pkg::FUNCT_SUB, fpu_pkg::FRM_RNE);
      issue("cancel 3-3", 32'h40400000, 32'h40400000, fpu_pkg::FUNCT_SUB, fpu_pkg::FRM_RDN);
      issue("cancel 3+-3", 32'h40400000, 32'hC0400000, fpu_pkg::FUNCT_ADD, fpu_pkg::FRM_RNE);
      issue("mul 1.5*1.5", 32'h3FC00000, 32'h3FC00000, fpu_pkg::FUNCT_MUL, fpu_pkg::FRM_RNE);
      issue("mul 3*-2", 32'h40400000, 32'hC0000000, fpu_pkg::FUNCT_MUL, fpu_pkg::FRM_RNE);
      issue("mul -3*0", 32'hC0400000, 32'h00000000, fpu_pkg::FUNCT_MUL, fpu_pkg::FRM_RNE);

      for (int m = 0; m < 6; m++) begin
         for (int p = 0; p < 5; p++) begin
            issue($sformatf("round pair %0d frm %0d", p, mode_list[m]),
                  pair_a[p], pair_b[p], pair_op[p], mode_list[m]);
         end
      end

      // specials and range limits
      issue("inf-inf", 32'h7F800000, 32'h7F800000, fpu_pkg::FUNCT_SUB, fpu_pkg::FRM_RNE);
      issue("0*inf", 32'h00000000, 32'h7F800000, fpu_pkg::FUNCT_MUL, fpu_pkg::FRM_RNE);
      issue("nan add", 32'h7FC00001, 32'h3F800000, fpu_pkg::FUNCT_ADD, fpu_pkg::FRM_RNE);
      issue("nan mul", 32'h3F800000, 32'hFF800001, fpu_pkg::FUNCT_MUL, fpu_pkg::FRM_RNE);
      issue("inf+1", 32'h7F800000, 32'h3F800000, fpu_pkg::FUNCT_ADD, fpu_pkg::FRM_RNE);
      issue("1-inf", 32'h3F800000, 32'h7F800000, fpu_pkg::FUNCT_SUB, fpu_pkg::FRM_RNE);
      issue("denormal add", 32'h00000123, 32'h40400000, fpu_pkg::FUNCT_ADD, fpu_pkg::FRM_RNE);
      issue("denormal mul", 32'h00000123, 32'h40400000, fpu_pkg::FUNCT_MUL, fpu_pkg::FRM_RNE);
      issue("overflow", 32'h7F000000, 32'h7F000000, fpu_pkg::FUNCT_MUL, fpu_pkg::FRM_RNE);
      issue("underflow", 32'h00800000, 32'h80800000, fpu_pkg::FUNCT_MUL, fpu_pkg::FRM_RNE);
      issue("unknown funct", 32'h3F800000, 32'h3F800000, 7'h7F, fpu_pkg::FRM_RNE);

      // back-to-back random stream
      for (int i = 0; i < 400; i++) begin
         rng = xorshift32(rng);
         r1  = rng;
         rng = xorshift32(rng);
         r2  = rng;
         rng = xorshift32(rng);
         r3  = rng;
         rng = xorshift32(rng);
         r4  = rng;
         case (r4[17:16])
            2'd0:    op = fpu_pkg::FUNCT_ADD;
            2'd1:    op = fpu_pkg::FUNCT_SUB;
            default: op = fpu_pkg::FUNCT_MUL;
         endcase
         issue($sformatf("random %0d", i), random_normal(r1, r2), random_normal(r3, r4),
               op, r4[22:20]);
      end

      @(negedge clk);
      funct = '0;
      wait_cycles = 0;
      while (due_q.size() > 0 && wait_cycles < 20) begin
         @(negedge clk);
         wait_cycles++;
      end
      if (due_q.size() > 0) begin
         drain_errors++;
         $display("results did not drain, %0d operations still pending", due_q.size());
      end

      $display("errors: %0d result, %0d flags, %0d drain", word_errors, flag_errors,
               drain_errors);
      if (word_errors + flag_errors + drain_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
hw/fpu_pkg.sv
hw/fpu_decode.sv
hw/fpu_execute.sv
hw/fpu_result.sv
hw/fpu_top.sv
testbench/fpu_tb.sv

// File: Makefile
SIM       ?= verilator
TOP       ?= fpu_tb
BUILD_DIR ?= obj_dir
SIM_FLAGS ?= --binary -j 0 --timing
FILE_LIST ?= src.f

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)
